// File: mem_bus_pkg.sv
package mem_bus_pkg;

   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   typedef logic [ADDR_W-1:0] mem_addr_t;
   typedef logic [DATA_W-1:0] mem_data_t;

   typedef struct packed {
      mem_addr_t address;
   } read_req_t;

   typedef struct packed {
      mem_addr_t address;
      mem_data_t data;
   } write_req_t;

   // stores issued by execute and not yet accepted by memory
   typedef logic [1:0] store_count_t;

endpackage

// File: pipe_types_pkg.sv
package pipe_types_pkg;

   localparam int WORD_W    = 32;
   localparam int NUM_REGS  = 8;
   localparam int REG_IDX_W = 3;

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_mov
   } alu_op_e;

   // rr: dst op src, ri: dst op imm, rm: dst op mem, mr: mem op src back to mem
   typedef enum logic [1:0] {
      mode_rr,
      mode_ri,
      mode_rm,
      mode_mr
   } op_mode_e;

   // imm doubles as displacement in the memory modes
   typedef struct packed {
      alu_op_e  alu_op;
      op_mode_e mode;
      reg_idx_t dst;
      reg_idx_t src;
      reg_idx_t base;
      word_t    imm;
   } uop_t;

   typedef struct packed {
      alu_op_e  alu_op;
      op_mode_e mode;
      reg_idx_t dst;
      word_t    op_a;
      word_t    op_b;
      word_t    base_value;
      word_t    imm;
   } regs_stage_t;

   typedef struct packed {
      alu_op_e  alu_op;
      op_mode_e mode;
      reg_idx_t dst;
      word_t    op_a;
      word_t    op_b;
      word_t    address;
   } addr_stage_t;

   // memory operand already merged into op_a or op_b
   typedef struct packed {
      alu_op_e  alu_op;
      op_mode_e mode;
      reg_idx_t dst;
      word_t    op_a;
      word_t    op_b;
      word_t    address;
   } exe_stage_t;

   typedef struct packed {
      reg_idx_t dst;
      word_t    value;
   } commit_t;

endpackage

// File: register_access.sv
`timescale 1ns/1ps

module register_access (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        uop_valid,
   output logic                        uop_ready,
   input  pipe_types_pkg::uop_t        uop,
   output logic                        regs_valid,
   input  logic                        regs_ready,
   output pipe_types_pkg::regs_stage_t regs,
   input  logic                        commit_valid,
   input  pipe_types_pkg::commit_t     commit
);

   pipe_types_pkg::word_t               rf [pipe_types_pkg::NUM_REGS];
   logic [pipe_types_pkg::NUM_REGS-1:0] busy;
   logic [pipe_types_pkg::NUM_REGS-1:0] busy_set;
   logic [pipe_types_pkg::NUM_REGS-1:0] busy_clr;
   logic                                uses_dst;
   logic                                uses_src;
   logic                                uses_base;
   logic                                blocked;
   logic                                accept;

   // dst is read and written in every mode but mr
   assign uses_dst  = (uop.mode != pipe_types_pkg::mode_mr);
   assign uses_src  = (uop.mode == pipe_types_pkg::mode_rr) ||
                      (uop.mode == pipe_types_pkg::mode_mr);
   assign uses_base = (uop.mode == pipe_types_pkg::mode_rm) ||
                      (uop.mode == pipe_types_pkg::mode_mr);

   // no bypass, wait for the writeback edge
   assign blocked = (uses_dst && busy[uop.dst]) ||
                    (uses_src && busy[uop.src]) ||
                    (uses_base && busy[uop.base]);

   assign uop_ready = !blocked && (!regs_valid || regs_ready);
   assign accept    = uop_valid && uop_ready;

   always_comb begin
      busy_set = '0;
      busy_clr = '0;
      if (accept && uses_dst) begin
         busy_set[uop.dst] = 1'b1;
      end
      if (commit_valid) begin
         busy_clr[commit.dst] = 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy       <= '0;
         regs_valid <= 1'b0;
      end else begin
         busy       <= (busy & ~busy_clr) | busy_set;
         regs_valid <= accept || (regs_valid && !regs_ready);
      end
   end

   // register file, cleared so reads after reset see zero
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < pipe_types_pkg::NUM_REGS; i++) begin
            rf[i] <= '0;
         end
      end else if (commit_valid) begin
         rf[commit.dst] <= commit.value;
      end
   end

   // operand latch
   always_ff @(posedge clk) begin
      if (accept) begin
         regs.alu_op     <= uop.alu_op;
         regs.mode       <= uop.mode;
         regs.dst        <= uop.dst;
         regs.op_a       <= rf[uop.dst];
         regs.op_b       <= (uop.mode == pipe_types_pkg::mode_ri) ? uop.imm : rf[uop.src];
         regs.base_value <= rf[uop.base];
         regs.imm        <= uop.imm;
      end
   end

endmodule

// File: address_generation.sv
`timescale 1ns/1ps

module address_generation (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        regs_valid,
   output logic                        regs_ready,
   input  pipe_types_pkg::regs_stage_t regs,
   output logic                        addr_valid,
   input  logic                        addr_ready,
   output pipe_types_pkg::addr_stage_t addr
);

   logic                  accept;
   logic                  is_mem;
   pipe_types_pkg::word_t eff_addr;

   assign regs_ready = !addr_valid || addr_ready;
   assign accept     = regs_valid && regs_ready;

   assign is_mem = (regs.mode == pipe_types_pkg::mode_rm) ||
                   (regs.mode == pipe_types_pkg::mode_mr);

   // base plus displacement, wraps at 32 bits
   assign eff_addr = is_mem ? (regs.base_value + regs.imm) : '0;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         addr_valid <= 1'b0;
      end else begin
         addr_valid <= accept || (addr_valid && !addr_ready);
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         addr.alu_op  <= regs.alu_op;
         addr.mode    <= regs.mode;
         addr.dst     <= regs.dst;
         addr.op_a    <= regs.op_a;
         addr.op_b    <= regs.op_b;
         addr.address <= eff_addr;
      end
   end

endmodule

// File: memory_read.sv
`timescale 1ns/1ps

module memory_read (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        addr_valid,
   output logic                        addr_ready,
   input  pipe_types_pkg::addr_stage_t addr,
   output logic                        exe_valid,
   input  logic                        exe_ready,
   output pipe_types_pkg::exe_stage_t  exe,
   output logic                        rmem_valid,
   input  logic                        rmem_ready,
   output mem_bus_pkg::read_req_t      rmem_req,
   input  logic                        rmem_dp_valid,
   output logic                        rmem_dp_ready,
   input  mem_bus_pkg::mem_data_t      rmem_dp_data,
   input  logic                        store_done
);

   typedef enum logic [1:0] {idle, request, wait_data, hold} state_e;

   state_e                     state;
   state_e                     state_next;
   pipe_types_pkg::exe_stage_t item;
   mem_bus_pkg::store_count_t  store_cnt;
   logic                       accept;
   logic                       is_mem;
   logic                       to_exe;
   logic                       store_issue;
   logic                       data_in;

   assign is_mem = (addr.mode == pipe_types_pkg::mode_rm) ||
                   (addr.mode == pipe_types_pkg::mode_mr);

   // hold frees up in the same cycle execute takes the item
   assign addr_ready  = (state == idle) || ((state == hold) && exe_ready);
   assign accept      = addr_valid && addr_ready;
   assign exe_valid   = (state == hold);
   assign exe         = item;
   assign to_exe      = exe_valid && exe_ready;
   assign store_issue = to_exe && (item.mode == pipe_types_pkg::mode_mr);

   // loads wait until every older store has reached memory
   assign rmem_valid       = (state == request) && (store_cnt == '0);
   assign rmem_req.address = item.address;
   assign rmem_dp_ready    = (state == wait_data);
   assign data_in          = rmem_dp_valid && rmem_dp_ready;

   always_comb begin
      state_next = state;
      case (state)
         idle, hold: begin
            if (accept) begin
               state_next = is_mem ? request : hold;
            end else if (to_exe) begin
               state_next = idle;
            end
         end
         request: begin
            if (rmem_valid && rmem_ready) begin
               state_next = wait_data;
            end
         end
         wait_data: begin
            if (rmem_dp_valid) begin
               state_next = hold;
            end
         end
         default: state_next = idle;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= idle;
         store_cnt <= '0;
      end else begin
         state <= state_next;
         case ({store_issue, store_done})
            2'b10:   store_cnt <= store_cnt + 2'd1;
            2'b01:   store_cnt <= store_cnt - 2'd1;
            default: store_cnt <= store_cnt;
         endcase
      end
   end

   // memory data goes to op_b for loads, op_a for read-modify-write
   always_ff @(posedge clk) begin
      if (accept) begin
         item.alu_op  <= addr.alu_op;
         item.mode    <= addr.mode;
         item.dst     <= addr.dst;
         item.op_a    <= addr.op_a;
         item.op_b    <= addr.op_b;
         item.address <= addr.address;
      end else if (data_in) begin
         if (item.mode == pipe_types_pkg::mode_rm) begin
            item.op_b <= rmem_dp_data;
         end else begin
            item.op_a <= rmem_dp_data;
         end
      end
   end

endmodule

// File: execute.sv
`timescale 1ns/1ps

module execute (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       exe_valid,
   output logic                       exe_ready,
   input  pipe_types_pkg::exe_stage_t exe,
   output logic                       commit_valid,
   output pipe_types_pkg::commit_t    commit,
   output logic                       wmem_valid,
   input  logic                       wmem_ready,
   output mem_bus_pkg::write_req_t    wmem_req,
   output logic                       store_done
);

   pipe_types_pkg::word_t result;
   logic                  accept;
   logic                  is_store;

   always_comb begin
      case (exe.alu_op)
         pipe_types_pkg::alu_add: result = exe.op_a + exe.op_b;
         pipe_types_pkg::alu_sub: result = exe.op_a - exe.op_b;
         pipe_types_pkg::alu_and: result = exe.op_a & exe.op_b;
         pipe_types_pkg::alu_or:  result = exe.op_a | exe.op_b;
         pipe_types_pkg::alu_xor: result = exe.op_a ^ exe.op_b;
         default:                 result = exe.op_b;
      endcase
   end

   // only a pending write can stall this stage
   assign exe_ready  = !wmem_valid || wmem_ready;
   assign accept     = exe_valid && exe_ready;
   assign is_store   = (exe.mode == pipe_types_pkg::mode_mr);
   assign store_done = wmem_valid && wmem_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         commit_valid <= 1'b0;
         wmem_valid   <= 1'b0;
      end else begin
         commit_valid <= accept && !is_store;
         wmem_valid   <= (accept && is_store) || (wmem_valid && !wmem_ready);
      end
   end

   always_ff @(posedge clk) begin
      if (accept && !is_store) begin
         commit.dst   <= exe.dst;
         commit.value <= result;
      end
      // write request stays put until memory takes it
      if (accept && is_store) begin
         wmem_req.address <= exe.address;
         wmem_req.data    <= result;
      end
   end

endmodule

// File: pipeline_top.sv
`timescale 1ns/1ps

module pipeline_top (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    uop_valid,
   output logic                    uop_ready,
   input  pipe_types_pkg::uop_t    uop,
   output logic                    rmem_valid,
   input  logic                    rmem_ready,
   output mem_bus_pkg::read_req_t  rmem_req,
   input  logic                    rmem_dp_valid,
   output logic                    rmem_dp_ready,
   input  mem_bus_pkg::mem_data_t  rmem_dp_data,
   output logic                    wmem_valid,
   input  logic                    wmem_ready,
   output mem_bus_pkg::write_req_t wmem_req,
   output logic                    commit_valid,
   output pipe_types_pkg::commit_t commit
);

   logic                        regs_valid;
   logic                        regs_ready;
   pipe_types_pkg::regs_stage_t regs;
   logic                        addr_valid;
   logic                        addr_ready;
   pipe_types_pkg::addr_stage_t addr;
   logic                        exe_valid;
   logic                        exe_ready;
   pipe_types_pkg::exe_stage_t  exe;
   logic                        store_done;

   register_access i_register_access (
      .clk          (clk),
      .rst_n        (rst_n),
      .uop_valid    (uop_valid),
      .uop_ready    (uop_ready),
      .uop          (uop),
      .regs_valid   (regs_valid),
      .regs_ready   (regs_ready),
      .regs         (regs),
      .commit_valid (commit_valid),
      .commit       (commit)
   );

   address_generation i_address_generation (
      .clk        (clk),
      .rst_n      (rst_n),
      .regs_valid (regs_valid),
      .regs_ready (regs_ready),
      .regs       (regs),
      .addr_valid (addr_valid),
      .addr_ready (addr_ready),
      .addr       (addr)
   );

   memory_read i_memory_read (
      .clk           (clk),
      .rst_n         (rst_n),
      .addr_valid    (addr_valid),
      .addr_ready    (addr_ready),
      .addr          (addr),
      .exe_valid     (exe_valid),
      .exe_ready     (exe_ready),
      .exe           (exe),
      .rmem_valid    (rmem_valid),
      .rmem_ready    (rmem_ready),
      .rmem_req      (rmem_req),
      .rmem_dp_valid (rmem_dp_valid),
      .rmem_dp_ready (rmem_dp_ready),
      .rmem_dp_data  (rmem_dp_data),
      .store_done    (store_done)
   );

   // commit also feeds back to the register file
   execute i_execute (
      .clk          (clk),
      .rst_n        (rst_n),
      .exe_valid    (exe_valid),
      .exe_ready    (exe_ready),
      .exe          (exe),
      .commit_valid (commit_valid),
      .commit       (commit),
      .wmem_valid   (wmem_valid),
      .wmem_ready   (wmem_ready),
      .wmem_req     (wmem_req),
      .store_done   (store_done)
   );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk,
   output logic rst_n
);

   localparam int HALF_PERIOD  = 20;
   localparam int RESET_CYCLES = 10;

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // release just after an edge, like every other testbench input
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #2 rst_n = 1'b1;
   end

endmodule

// File: tb_pipeline_top.sv
`timescale 1ns/1ps

module tb_pipeline_top;

   localparam int          CLK_PERIOD   = 40;
   localparam int          RESET_CYCLES = 10;
   localparam int          DRIVE_DELAY  = 2;
   localparam int          TOTAL_UOPS   = 268;
   localparam logic [31:0] SEED         = 32'h0b66_49d0;

   logic                    clk;
   logic                    rst_n;
   logic                    uop_valid;
   logic                    uop_ready;
   pipe_types_pkg::uop_t    uop;
   logic                    rmem_valid;
   logic                    rmem_ready;
   mem_bus_pkg::read_req_t  rmem_req;
   logic                    rmem_dp_valid;
   logic                    rmem_dp_ready;
   mem_bus_pkg::mem_data_t  rmem_dp_data;
   logic                    wmem_valid;
   logic                    wmem_ready;
   mem_bus_pkg::write_req_t wmem_req;
   logic                    commit_valid;
   pipe_types_pkg::commit_t commit;

   // reference state updated in issue order
   pipe_types_pkg::word_t   model_regs [pipe_types_pkg::NUM_REGS];
   pipe_types_pkg::word_t   model_mem [256];
   // memory seen by the DUT ports
   mem_bus_pkg::mem_data_t  dut_mem [256];
   pipe_types_pkg::commit_t exp_commits [$];
   mem_bus_pkg::read_req_t  exp_reads [$];
   mem_bus_pkg::write_req_t exp_writes [$];
   logic [31:0]             main_rng = SEED;
   logic [31:0]             rd_rng = SEED ^ 32'h0000_0001;
   logic [31:0]             wr_rng = SEED ^ 32'h0000_0002;
   int                      mismatch_count = 0;
   int                      other_count = 0;
   int                      issued_count = 0;

   tb_clock_gen i_tb_clock_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   pipeline_top i_pipeline_top (
      .clk           (clk),
      .rst_n         (rst_n),
      .uop_valid     (uop_valid),
      .uop_ready     (uop_ready),
      .uop           (uop),
      .rmem_valid    (rmem_valid),
      .rmem_ready    (rmem_ready),
      .rmem_req      (rmem_req),
      .rmem_dp_valid (rmem_dp_valid),
      .rmem_dp_ready (rmem_dp_ready),
      .rmem_dp_data  (rmem_dp_data),
      .wmem_valid    (wmem_valid),
      .wmem_ready    (wmem_ready),
      .wmem_req      (wmem_req),
      .commit_valid  (commit_valid),
      .commit        (commit)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] rand_main();
      main_rng = xorshift(main_rng);
      return main_rng;
   endfunction

   function automatic pipe_types_pkg::alu_op_e random_op();
      logic [31:0] r;
      r = rand_main() % 6;
      return pipe_types_pkg::alu_op_e'(r[2:0]);
   endfunction

   function automatic pipe_types_pkg::op_mode_e random_mode();
      logic [31:0] r;
      r = rand_main();
      return pipe_types_pkg::op_mode_e'(r[1:0]);
   endfunction

   function automatic pipe_types_pkg::reg_idx_t random_reg();
      logic [31:0] r;
      r = rand_main();
      return r[2:0];
   endfunction

   // every index bit shows up in each byte
   function automatic pipe_types_pkg::word_t fill_word(input logic [7:0] idx);
      return {idx, ~idx, idx ^ 8'h5a, {idx[3:0], idx[7:4]}};
   endfunction

   function automatic pipe_types_pkg::word_t alu_model(input pipe_types_pkg::alu_op_e op,
                                                       input pipe_types_pkg::word_t a,
                                                       input pipe_types_pkg::word_t b);
      case (op)
         pipe_types_pkg::alu_add: return a + b;
         pipe_types_pkg::alu_sub: return a - b;
         pipe_types_pkg::alu_and: return a & b;
         pipe_types_pkg::alu_or:  return a | b;
         pipe_types_pkg::alu_xor: return a ^ b;
         default:                 return b;
      endcase
   endfunction

   function automatic pipe_types_pkg::uop_t make_uop(input pipe_types_pkg::alu_op_e op,
                                                     input pipe_types_pkg::op_mode_e mode,
                                                     input pipe_types_pkg::reg_idx_t dst,
                                                     input pipe_types_pkg::reg_idx_t src,
                                                     input pipe_types_pkg::reg_idx_t base,
                                                     input pipe_types_pkg::word_t imm);
      pipe_types_pkg::uop_t u;
      u.alu_op = op;
      u.mode   = mode;
      u.dst    = dst;
      u.src    = src;
      u.base   = base;
      u.imm    = imm;
      return u;
   endfunction

   task automatic step_cycle();
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic check_commit(input pipe_types_pkg::commit_t actual,
                               input pipe_types_pkg::commit_t expected);
      if (actual !== expected) begin
         mismatch_count++;
         $display("Mismatch at %0t ns: commit dst %0d value %h, expected dst %0d value %h",
                  $time, actual.dst, actual.value, expected.dst, expected.value);
      end
   endtask

   task automatic check_read(input mem_bus_pkg::read_req_t actual,
                             input mem_bus_pkg::read_req_t expected);
      if (actual !== expected) begin
         mismatch_count++;
         $display("Mismatch at %0t ns: rmem_req address %h, expected %h",
                  $time, actual.address, expected.address);
      end
   endtask

   task automatic check_write(input mem_bus_pkg::write_req_t actual,
                              input mem_bus_pkg::write_req_t expected);
      if (actual !== expected) begin
         mismatch_count++;
         $display("Mismatch at %0t ns: wmem_req address %h data %h, expected %h data %h",
                  $time, actual.address, actual.data, expected.address, expected.data);
      end
   endtask

   // model the micro-op in program order before handing it to the DUT
   task automatic issue_uop(input pipe_types_pkg::uop_t u);
      pipe_types_pkg::word_t   a;
      pipe_types_pkg::word_t   b;
      pipe_types_pkg::word_t   res;
      mem_bus_pkg::mem_addr_t  ad;
      pipe_types_pkg::commit_t c;
      mem_bus_pkg::read_req_t  rq;
      mem_bus_pkg::write_req_t wq;
      logic                    taken;
      ad = model_regs[u.base] + u.imm;
      a  = model_regs[u.dst];
      b  = model_regs[u.src];
      if (u.mode == pipe_types_pkg::mode_ri) begin
         b = u.imm;
      end else if (u.mode == pipe_types_pkg::mode_rm) begin
         b = model_mem[ad[9:2]];
      end else if (u.mode == pipe_types_pkg::mode_mr) begin
         a = model_mem[ad[9:2]];
      end
      res = alu_model(u.alu_op, a, b);
      if (u.mode == pipe_types_pkg::mode_rm || u.mode == pipe_types_pkg::mode_mr) begin
         rq.address = ad;
         exp_reads.push_back(rq);
      end
      if (u.mode == pipe_types_pkg::mode_mr) begin
         wq.address = ad;
         wq.data    = res;
         exp_writes.push_back(wq);
         model_mem[ad[9:2]] = res;
      end else begin
         c.dst   = u.dst;
         c.value = res;
         exp_commits.push_back(c);
         model_regs[u.dst] = res;
      end
      uop_valid = 1'b1;
      uop       = u;
      do begin
         @(negedge clk);
         taken = uop_ready;
         step_cycle();
      end while (!taken);
      uop_valid = 1'b0;
      issued_count++;
   endtask

   task automatic wait_idle();
      while (exp_commits.size() != 0 || exp_reads.size() != 0 || exp_writes.size() != 0) begin
         @(negedge clk);
      end
      step_cycle();
   endtask

   task automatic print_counts();
      $display("mismatches %0d, other errors %0d, micro-ops issued %0d",
               mismatch_count, other_count, issued_count);
   endtask

   task automatic after_reset();
      if (uop_ready !== 1'b1) begin
         other_count++;
         $display("uop_ready is not high after reset");
      end
      if (rmem_valid !== 1'b0 || rmem_dp_ready !== 1'b0 || wmem_valid !== 1'b0 ||
          commit_valid !== 1'b0) begin
         other_count++;
         $display("a memory or commit handshake output is not low after reset");
      end
   endtask

   task automatic alu_ops();
      for (int r = 0; r < 8; r++) begin
         issue_uop(make_uop(pipe_types_pkg::alu_mov, pipe_types_pkg::mode_ri,
                            3'(r), 3'd0, 3'd0, rand_main()));
      end
      for (int k = 0; k < 6; k++) begin
         issue_uop(make_uop(pipe_types_pkg::alu_op_e'(3'(k)), pipe_types_pkg::mode_rr,
                            3'(k), 3'(k + 3), 3'd0, '0));
         issue_uop(make_uop(pipe_types_pkg::alu_op_e'(3'(k)), pipe_types_pkg::mode_ri,
                            3'(k + 1), 3'd0, 3'd0, rand_main()));
      end
      wait_idle();
   endtask

   // each op reads the register the previous one wrote
   task automatic dependency_chains();
      pipe_types_pkg::reg_idx_t prev;
      pipe_types_pkg::reg_idx_t next;
      prev = random_reg();
      for (int k = 0; k < 16; k++) begin
         next = random_reg();
         issue_uop(make_uop(pipe_types_pkg::alu_op_e'(3'(k % 6)), pipe_types_pkg::mode_rr,
                            next, prev, 3'd0, '0));
         prev = next;
      end
      wait_idle();
   endtask

   task automatic memory_loads();
      for (int k = 0; k < 16; k++) begin
         issue_uop(make_uop(random_op(), pipe_types_pkg::mode_rm,
                            random_reg(), 3'd0, random_reg(), rand_main()));
      end
      wait_idle();
   endtask

   task automatic read_modify_write();
      pipe_types_pkg::reg_idx_t base;
      pipe_types_pkg::word_t    disp;
      for (int k = 0; k < 8; k++) begin
         base = random_reg();
         disp = rand_main();
         issue_uop(make_uop(pipe_types_pkg::alu_op_e'(3'(k % 6)), pipe_types_pkg::mode_mr,
                            3'd0, random_reg(), base, disp));
         // load straight back from the word just stored
         issue_uop(make_uop(pipe_types_pkg::alu_mov, pipe_types_pkg::mode_rm,
                            random_reg(), 3'd0, base, disp));
      end
      wait_idle();
   endtask

   task automatic random_mix();
      for (int k = 0; k < 200; k++) begin
         issue_uop(make_uop(random_op(), random_mode(), random_reg(), random_reg(),
                            random_reg(), rand_main()));
         if (rand_main() % 4 == 0) begin
            step_cycle();
         end
      end
      wait_idle();
   endtask

   initial begin
      uop_valid = 1'b0;
      uop       = '0;
      for (int i = 0; i < 256; i++) begin
         model_mem[i] = fill_word(8'(i));
         dut_mem[i]   = fill_word(8'(i));
      end
      for (int i = 0; i < pipe_types_pkg::NUM_REGS; i++) begin
         model_regs[i] = '0;
      end
      @(posedge rst_n);
      after_reset();
      alu_ops();
      dependency_chains();
      memory_loads();
      read_modify_write();
      random_mix();
      print_counts();
      if (mismatch_count == 0 && other_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // commits are never stalled and every pulse is checked
   always @(negedge clk) begin
      if (rst_n && commit_valid) begin
         if (exp_commits.size() == 0) begin
            other_count++;
            $display("commit to r%0d at %0t ns with none expected", commit.dst, $time);
         end else begin
            check_commit(commit, exp_commits.pop_front());
         end
      end
   end

   // read port with random request and data delays
   initial begin : read_port
      int unsigned            gap;
      mem_bus_pkg::read_req_t req;
      rmem_ready    = 1'b0;
      rmem_dp_valid = 1'b0;
      rmem_dp_data  = '0;
      forever begin
         @(negedge clk);
         if (rst_n && rmem_valid) begin
            rd_rng = xorshift(rd_rng);
            gap = rd_rng % 4;
            step_cycle();
            repeat (gap) step_cycle();
            rmem_ready = 1'b1;
            @(negedge clk);
            req = rmem_req;
            if (exp_reads.size() == 0) begin
               other_count++;
               $display("read of %h at %0t ns with none expected", req.address, $time);
            end else begin
               check_read(req, exp_reads.pop_front());
            end
            step_cycle();
            rmem_ready = 1'b0;
            rd_rng = xorshift(rd_rng);
            gap = rd_rng % 4;
            repeat (gap) step_cycle();
            rmem_dp_valid = 1'b1;
            rmem_dp_data  = dut_mem[req.address[9:2]];
            @(negedge clk);
            while (!rmem_dp_ready) begin
               @(negedge clk);
            end
            step_cycle();
            rmem_dp_valid = 1'b0;
         end
      end
   end

   // write port with random back-pressure
   initial begin : write_port
      int unsigned gap;
      wmem_ready = 1'b0;
      forever begin
         @(negedge clk);
         if (rst_n && wmem_valid) begin
            wr_rng = xorshift(wr_rng);
            gap = wr_rng % 4;
            step_cycle();
            repeat (gap) step_cycle();
            wmem_ready = 1'b1;
            @(negedge clk);
            if (exp_writes.size() == 0) begin
               other_count++;
               $display("write to %h at %0t ns with none expected", wmem_req.address, $time);
            end else begin
               check_write(wmem_req, exp_writes.pop_front());
            end
            dut_mem[wmem_req.address[9:2]] = wmem_req.data;
            step_cycle();
            wmem_ready = 1'b0;
         end
      end
   end

   initial begin : watchdog
      #((RESET_CYCLES + 50 * TOTAL_UOPS) * CLK_PERIOD);
      other_count++;
      $display("timeout: the pipeline stopped before all micro-ops completed");
      print_counts();
      $display("Errors found");
      $finish;
   end

endmodule

// File: src.f
mem_bus_pkg.sv
pipe_types_pkg.sv
register_access.sv
address_generation.sv
memory_read.sv
execute.sv
pipeline_top.sv
tb_clock_gen.sv
tb_pipeline_top.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_pipeline_top
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

# pass only when the log holds the pass line
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
